// ==== compile.f ====
design/des_pkg.sv
design/word_receiver.sv
design/packet_assembler.sv
design/crc4_checker.sv
design/alu_deserializer.sv
bench/alu_deserializer_properties.sv
bench/tb_alu_deserializer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alu_deserializer -f compile.f \
    || { echo "Verilator build failed"; exit 1; }

sim_output=$(./obj_dir/Vtb_alu_deserializer)
echo "$sim_output"

echo "$sim_output" | grep -qx "sim passed" && exit 0 || exit 1

// ==== bench/tb_alu_deserializer.sv ====
module tb_alu_deserializer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int oversample  = 16;
    localparam int num_rounds  = 75;
    localparam int max_packets = 2 * num_rounds;
    localparam int max_gap     = 40;
    localparam int cycle_limit =
        max_packets * 9 * (des_pkg::word_bits * oversample + max_gap) * 2;

    localparam int kind_ack   = 0;
    localparam int kind_frame = 1;
    localparam int kind_crc   = 2;

    logic                 clk;
    logic                 rst;
    logic                 serial_in;
    des_pkg::alu_packet_t result;
    logic                 ack;
    logic                 frame_error;
    logic                 crc_error;

    // Pending pulses in arrival order along with the packet an ack must show
    int                   pend_kind[$];
    des_pkg::alu_packet_t pend_pkt[$];
    des_pkg::alu_packet_t good_result;
    des_pkg::alu_packet_t want_pkt;
    int                   want_kind;
    int                   obs_kind;
    int                   exp_ack;
    int                   exp_frame;
    int                   exp_crc;
    int                   obs_ack;
    int                   obs_frame;
    int                   obs_crc;
    int                   errors;
    int                   cycle_count;

    alu_deserializer #(
        .OVERSAMPLE  (oversample)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .serial_in   (serial_in),
        .result      (result),
        .ack         (ack),
        .frame_error (frame_error),
        .crc_error   (crc_error)
    );

    bind alu_deserializer alu_deserializer_properties u_properties (
        .clk         (clk),
        .rst         (rst),
        .ack         (ack),
        .frame_error (frame_error),
        .crc_error   (crc_error)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ///////////////////////////////////////////////////////////////////////
    // Reference model
    ///////////////////////////////////////////////////////////////////////

    // Remainder of A, B, 1 and opcode times x^4 over x^4+x+1
    function automatic logic [3:0] crc_model(
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [2:0]  op
    );
        logic [71:0] rem;
        rem = {a, b, 1'b1, op, 4'b0000};
        for (int i = 71; i >= 4; i--)
        begin
            if (rem[i])
                rem[i -: 5] = rem[i -: 5] ^ 5'b10011;
        end
        return rem[3:0];
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            kind_ack:   return "ack";
            kind_frame: return "frame_error";
            default:    return "crc_error";
        endcase
    endfunction

    task automatic expect_pulse(input int kind, input des_pkg::alu_packet_t pkt);
        pend_kind.push_back(kind);
        pend_pkt.push_back(pkt);
        if (kind == kind_ack)
            exp_ack++;
        else if (kind == kind_frame)
            exp_frame++;
        else
            exp_crc++;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Serial line driver
    ///////////////////////////////////////////////////////////////////////

    task automatic drive_level(input logic level, input int cycles);
        if (cycles > 0)
        begin
            @(posedge clk);
            serial_in <= level;
            repeat (cycles - 1) @(posedge clk);
        end
    endtask

    task automatic send_word(input logic is_cmd, input logic [7:0] payload, input logic stop_bit);
        int gap;
        drive_level(1'b0, oversample);
        drive_level(is_cmd, oversample);
        for (int i = 7; i >= 0; i--)
            drive_level(payload[i], oversample);
        drive_level(stop_bit, oversample);
        gap = $urandom_range(max_gap, 0);
        // A low stop bit looks like a fresh start, so let that one die as a glitch
        if (!stop_bit)
            gap = gap + 20;
        drive_level(1'b1, gap);
    endtask

    task automatic send_data_words(input int count);
        logic [7:0] payload;
        for (int i = 0; i < count; i++)
        begin
            payload = 8'($urandom_range(255, 0));
            send_word(1'b0, payload, 1'b1);
        end
    endtask

    task automatic send_packet(
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [2:0]  op,
        input logic [3:0]  crc,
        input logic        marker
    );
        for (int i = 3; i >= 0; i--)
            send_word(1'b0, a[i*8 +: 8], 1'b1);
        for (int i = 3; i >= 0; i--)
            send_word(1'b0, b[i*8 +: 8], 1'b1);
        send_word(1'b1, {marker, op, crc}, 1'b1);
    endtask

    task automatic random_packet(output des_pkg::alu_packet_t pkt);
        pkt.a      = $urandom();
        pkt.b      = $urandom();
        pkt.opcode = 3'($urandom_range(7, 0));
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Test cases
    ///////////////////////////////////////////////////////////////////////

    task automatic send_good_packet();
        des_pkg::alu_packet_t pkt;
        random_packet(pkt);
        expect_pulse(kind_ack, pkt);
        send_packet(pkt.a, pkt.b, pkt.opcode, crc_model(pkt.a, pkt.b, pkt.opcode), 1'b1);
    endtask

    task automatic send_bad_crc();
        des_pkg::alu_packet_t pkt;
        logic [3:0]           crc;
        random_packet(pkt);
        crc = crc_model(pkt.a, pkt.b, pkt.opcode) ^ (4'b0001 << $urandom_range(3, 0));
        expect_pulse(kind_crc, pkt);
        send_packet(pkt.a, pkt.b, pkt.opcode, crc, 1'b1);
    endtask

    task automatic send_bad_stop();
        send_data_words($urandom_range(8, 0));
        expect_pulse(kind_frame, good_result);
        send_word(1'($urandom_range(1, 0)), 8'($urandom_range(255, 0)), 1'b0);
    endtask

    task automatic send_early_command();
        send_data_words($urandom_range(7, 0));
        expect_pulse(kind_frame, good_result);
        send_word(1'b1, {1'b1, 7'($urandom_range(127, 0))}, 1'b1);
    endtask

    task automatic send_ninth_data();
        send_data_words(8);
        expect_pulse(kind_frame, good_result);
        send_data_words(1);
    endtask

    task automatic send_zero_marker();
        send_data_words(8);
        expect_pulse(kind_frame, good_result);
        send_word(1'b1, {1'b0, 7'($urandom_range(127, 0))}, 1'b1);
    endtask

    // Low for less than half a bit
    task automatic send_glitch();
        drive_level(1'b0, $urandom_range(7, 1));
        drive_level(1'b1, 2 * oversample);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Output monitor
    ///////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (ack)
                obs_ack++;
            if (frame_error)
                obs_frame++;
            if (crc_error)
                obs_crc++;
            if (ack || frame_error || crc_error)
            begin
                obs_kind = ack ? kind_ack : (frame_error ? kind_frame : kind_crc);
                assert (pend_kind.size() != 0)
                else
                begin
                    errors++;
                    $display("Unexpected %s pulse at %0t while nothing was pending",
                             kind_name(obs_kind), $time);
                end
                if (pend_kind.size() != 0)
                begin
                    want_kind = pend_kind.pop_front();
                    want_pkt  = pend_pkt.pop_front();
                    assert (obs_kind == want_kind)
                    else
                    begin
                        errors++;
                        $display("[FAIL] %0t pulse: got %s expected %s",
                                 $time, kind_name(obs_kind), kind_name(want_kind));
                    end
                    if (ack && (want_kind == kind_ack))
                    begin
                        assert (result == want_pkt)
                        else
                        begin
                            errors++;
                            $display("[FAIL] %0t result: got %h expected %h",
                                     $time, result, want_pkt);
                        end
                        good_result = want_pkt;
                    end
                end
            end
            // Result moves only together with ack
            if (!ack)
            begin
                assert (result == good_result)
                else
                begin
                    errors++;
                    $display("[FAIL] %0t result: got %h expected %h", $time, result, good_result);
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Main sequence
    ///////////////////////////////////////////////////////////////////////

    initial
    begin
        int choice;
        serial_in   = 1'b1;
        rst         = 1'b0;
        good_result = '0;
        exp_ack     = 0;
        exp_frame   = 0;
        exp_crc     = 0;
        obs_ack     = 0;
        obs_frame   = 0;
        obs_crc     = 0;
        errors      = 0;
        void'($urandom(32'h463e_e370));
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);

        // Each round is an optional disturbance and then a good packet
        for (int r = 0; r < num_rounds; r++)
        begin
            choice = $urandom_range(6, 0);
            case (choice)
                1:       send_bad_crc();
                2:       send_bad_stop();
                3:       send_early_command();
                4:       send_ninth_data();
                5:       send_zero_marker();
                6:       send_glitch();
                default: ;
            endcase
            send_good_packet();
        end

        while (pend_kind.size() != 0)
            @(posedge clk);
        repeat (2 * oversample) @(posedge clk);

        assert (obs_ack == exp_ack)
        else
        begin
            errors++;
            $display("[FAIL] %0t ack count: got %0d expected %0d", $time, obs_ack, exp_ack);
        end
        assert (obs_frame == exp_frame)
        else
        begin
            errors++;
            $display("[FAIL] %0t frame_error count: got %0d expected %0d",
                     $time, obs_frame, exp_frame);
        end
        assert (obs_crc == exp_crc)
        else
        begin
            errors++;
            $display("[FAIL] %0t crc_error count: got %0d expected %0d", $time, obs_crc, exp_crc);
        end

        $display("acks %0d/%0d, frame errors %0d/%0d, crc errors %0d/%0d, check errors %0d",
                 obs_ack, exp_ack, obs_frame, exp_frame, obs_crc, exp_crc, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped at the limit of %0d cycles with %0d pulses still pending",
                 cycle_limit, pend_kind.size());
        $display("sim failed");
        $finish;
    end

endmodule

// ==== bench/alu_deserializer_properties.sv ====
module alu_deserializer_properties (
    input logic clk,
    input logic rst,
    input logic ack,
    input logic frame_error,
    input logic crc_error
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////
    // Status pulse rules
    //////////////////////////////////////////////////////////////////////

    // One outcome per cycle at most
    status_exclusive: assert property (
        @(posedge clk) disable iff (!rst) $onehot0({ack, frame_error, crc_error})
    ) else $error("More than one status pulse in the same cycle");

    // Single-cycle pulses
    ack_single: assert property (
        @(posedge clk) disable iff (!rst) ack |=> !ack
    ) else $error("ack held high for more than one cycle");

    frame_error_single: assert property (
        @(posedge clk) disable iff (!rst) frame_error |=> !frame_error
    ) else $error("frame_error held high for more than one cycle");

    crc_error_single: assert property (
        @(posedge clk) disable iff (!rst) crc_error |=> !crc_error
    ) else $error("crc_error held high for more than one cycle");

    // Quiet right after reset
    reset_quiet: assert property (
        @(posedge clk) !rst |=> !(ack || frame_error || crc_error)
    ) else $error("Status pulse in the cycle after reset");

endmodule

// ==== design/alu_deserializer.sv ====
module alu_deserializer #(
    parameter int OVERSAMPLE = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 serial_in,
    output des_pkg::alu_packet_t result,
    output logic                 ack,
    output logic                 frame_error,
    output logic                 crc_error
);

    // Receiver to assembler
    des_pkg::rx_word_t   rx_word;
    logic                word_valid;
    logic                word_error;

    // Assembler to checker
    des_pkg::rx_packet_t rx_packet;
    logic                packet_valid;

    //////////////////////////////////////////////////////////////////////
    // Serial word receiver
    //////////////////////////////////////////////////////////////////////

    word_receiver #(
        .OVERSAMPLE (OVERSAMPLE)
    ) u_word_receiver (
        .clk        (clk),
        .rst        (rst),
        .serial_in  (serial_in),
        .word       (rx_word),
        .word_valid (word_valid),
        .word_error (word_error)
    );

    // Words into operands and command
    packet_assembler u_packet_assembler (
        .clk          (clk),
        .rst          (rst),
        .word         (rx_word),
        .word_valid   (word_valid),
        .word_error   (word_error),
        .packet       (rx_packet),
        .packet_valid (packet_valid),
        .frame_error  (frame_error)
    );

    // CRC check and output hold
    crc4_checker u_crc4_checker (
        .clk          (clk),
        .rst          (rst),
        .packet       (rx_packet),
        .packet_valid (packet_valid),
        .result       (result),
        .ack          (ack),
        .crc_error    (crc_error)
    );

endmodule

// ==== design/crc4_checker.sv ====
module crc4_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  des_pkg::rx_packet_t  packet,
    input  logic                 packet_valid,
    output des_pkg::alu_packet_t result,
    output logic                 ack,
    output logic                 crc_error
);

    logic [des_pkg::crc_data_bits-1:0] crc_data;
    des_pkg::crc_t                     crc_calc;
    logic                              crc_match;

    // Bit-serial CRC, MSB first, zero seed
    function automatic des_pkg::crc_t crc4(
        input logic [des_pkg::crc_data_bits-1:0] data
    );
        des_pkg::crc_t crc;
        logic          feedback;
        crc = '0;
        for (int i = des_pkg::crc_data_bits - 1; i >= 0; i--)
        begin
            feedback = crc[3] ^ data[i];
            crc      = {crc[2:0], 1'b0} ^ (feedback ? des_pkg::crc_poly : '0);
        end
        return crc;
    endfunction

    // Marker bit is part of the protected string
    assign crc_data  = {packet.pkt.a, packet.pkt.b, 1'b1, packet.pkt.opcode};
    assign crc_calc  = crc4(crc_data);
    assign crc_match = (crc_calc == packet.crc);

    //////////////////////////////////////////////////////////////////////
    // Result register and status pulses
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            result    <= '0;
            ack       <= 1'b0;
            crc_error <= 1'b0;
        end
        else
        begin
            ack       <= packet_valid && crc_match;
            crc_error <= packet_valid && !crc_match;
            // Bad packets leave the last good one in place
            if (packet_valid && crc_match)
                result <= packet.pkt;
        end
    end

endmodule

// ==== design/packet_assembler.sv ====
module packet_assembler (
    input  logic                clk,
    input  logic                rst,
    input  des_pkg::rx_word_t   word,
    input  logic                word_valid,
    input  logic                word_error,
    output des_pkg::rx_packet_t packet,
    output logic                packet_valid,
    output logic                frame_error
);

    localparam int count_bits = $clog2(des_pkg::data_words + 1);
    localparam logic [count_bits-1:0] count_full = count_bits'(des_pkg::data_words);
    localparam logic [count_bits-1:0] count_half = count_bits'(des_pkg::data_words / 2);

    // Operand bits that survive one payload shift
    localparam int keep_bits = $bits(des_pkg::operand_t) - des_pkg::payload_bits;

    logic [count_bits-1:0] word_count;
    des_pkg::operand_t     operand_a;
    des_pkg::operand_t     operand_b;
    des_pkg::cmd_word_t    cmd;
    logic                  data_ok;
    logic                  cmd_ok;

    assign cmd = des_pkg::cmd_word_t'(word.payload);

    // Data word with room left in the packet
    assign data_ok = !word.is_cmd && (word_count != count_full);

    // Command closing a full packet with its marker set
    assign cmd_ok = word.is_cmd && (word_count == count_full) && cmd.marker;

    //////////////////////////////////////////////////////////////////////
    // Word sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            word_count   <= '0;
            packet_valid <= 1'b0;
            frame_error  <= 1'b0;
        end
        else
        begin
            packet_valid <= 1'b0;
            frame_error  <= 1'b0;
            if (word_error)
            begin
                frame_error <= 1'b1;
                word_count  <= '0;
            end
            else if (word_valid)
            begin
                if (data_ok)
                begin
                    word_count <= word_count + 1'b1;
                end
                else if (cmd_ok)
                begin
                    packet_valid <= 1'b1;
                    word_count   <= '0;
                end
                else
                begin
                    // Early command, ninth data word or bad marker
                    frame_error <= 1'b1;
                    word_count  <= '0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand collection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (word_valid && data_ok)
        begin
            if (word_count < count_half)
                operand_a <= {operand_a[keep_bits-1:0], word.payload};
            else
                operand_b <= {operand_b[keep_bits-1:0], word.payload};
        end
        if (word_valid && cmd_ok)
        begin
            packet.pkt.a      <= operand_a;
            packet.pkt.b      <= operand_b;
            packet.pkt.opcode <= cmd.opcode;
            packet.crc        <= cmd.crc;
        end
    end

endmodule

// ==== design/word_receiver.sv ====
module word_receiver #(
    parameter int OVERSAMPLE = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              serial_in,
    output des_pkg::rx_word_t word,
    output logic              word_valid,
    output logic              word_error
);

    localparam int phase_bits = $clog2(OVERSAMPLE);
    localparam int index_bits = $clog2(des_pkg::word_bits);

    // Phase value at which a bit is sampled
    localparam logic [phase_bits-1:0] phase_last = phase_bits'(OVERSAMPLE - 1);

    // Start offset so that the first sample lands mid start bit
    localparam logic [phase_bits-1:0] phase_half = phase_bits'(OVERSAMPLE / 2);

    localparam logic [index_bits-1:0] stop_index = index_bits'(des_pkg::word_bits - 1);

    typedef enum logic {
        st_idle,
        st_receive
    } state_t;

    state_t                      state;
    logic [phase_bits-1:0]       phase;
    logic [index_bits-1:0]       bit_index;
    logic [des_pkg::payload_bits:0] shift_reg;
    logic                        sample_point;

    // Middle of the current bit
    assign sample_point = (state == st_receive) && (phase == phase_last);

    //////////////////////////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state      <= st_idle;
            phase      <= '0;
            bit_index  <= '0;
            word_valid <= 1'b0;
            word_error <= 1'b0;
        end
        else
        begin
            word_valid <= 1'b0;
            word_error <= 1'b0;
            case (state)
                st_idle:
                begin
                    // Falling edge candidate
                    if (!serial_in)
                    begin
                        state     <= st_receive;
                        phase     <= phase_half;
                        bit_index <= '0;
                    end
                end
                st_receive:
                begin
                    if (sample_point)
                    begin
                        phase     <= '0;
                        bit_index <= bit_index + 1'b1;
                        if ((bit_index == '0) && serial_in)
                        begin
                            // Start bit gone by mid bit, a glitch
                            state <= st_idle;
                        end
                        else if (bit_index == stop_index)
                        begin
                            state      <= st_idle;
                            word_valid <= serial_in;
                            word_error <= !serial_in;
                        end
                    end
                    else
                    begin
                        phase <= phase + 1'b1;
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    // Start bit drops out the top after nine more samples
    always_ff @(posedge clk)
    begin
        if (sample_point)
        begin
            shift_reg <= {shift_reg[des_pkg::payload_bits-1:0], serial_in};
            if (bit_index == stop_index)
            begin
                // Kind and payload, stop bit not shifted in yet
                word <= des_pkg::rx_word_t'(shift_reg);
            end
        end
    end

endmodule

// ==== design/des_pkg.sv ====
package des_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Serial word format
    ///////////////////////////////////////////////////////////////////////

    // Start, kind, eight payload bits, stop
    localparam int word_bits = 11;

    // Payload bits per word, sent MSB first
    localparam int payload_bits = 8;

    // Data words per packet, half for each operand
    localparam int data_words = 8;

    ///////////////////////////////////////////////////////////////////////
    // Packet field types
    ///////////////////////////////////////////////////////////////////////

    // ALU operand, A or B
    typedef logic [31:0] operand_t;

    // ALU opcode
    typedef logic [2:0] opcode_t;

    // CRC value carried in the command word
    typedef logic [3:0] crc_t;

    // Generator x^4+x+1 without the x^4 term
    localparam crc_t crc_poly = 4'b0011;

    // A, B, one marker bit and the opcode
    localparam int crc_data_bits = 2 * $bits(operand_t) + 1 + $bits(opcode_t);

    ///////////////////////////////////////////////////////////////////////
    // Structured words and packets
    ///////////////////////////////////////////////////////////////////////

    // One received word, kind bit on top
    typedef struct packed {
        logic                    is_cmd;
        logic [payload_bits-1:0] payload;
    } rx_word_t;

    // Command payload layout
    typedef struct packed {
        logic    marker;
        opcode_t opcode;
        crc_t    crc;
    } cmd_word_t;

    // Complete packet as seen by the ALU
    typedef struct packed {
        operand_t a;
        operand_t b;
        opcode_t  opcode;
    } alu_packet_t;

    // Packet with the CRC still to be checked
    typedef struct packed {
        alu_packet_t pkt;
        crc_t        crc;
    } rx_packet_t;

endpackage
